// File: Makefile
# Verilator build of the counting engine testbench

VERILATOR ?= verilator
TOP ?= countingEngineTb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary -j 0
SOURCES ?= $(wildcard source/*.sv) $(wildcard testbench/*.sv)

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# exit status of the simulation is the test result
run: compile
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
source/graphPkg.sv
source/streamPkg.sv
source/delayLine.sv
source/graphPreprocessor.sv
source/componentCounter.sv
source/countingEngine.sv
testbench/countingEngineTb.sv

// File: source/componentCounter.sv
`timescale 1ns/1ns

module componentCounter (
    input logic clk,
    input logic reset,
    input logic inValid,
    input streamPkg::reducedJobT in,
    output logic freeSlot,
    output logic resultValid,
    input logic resultReady,
    output streamPkg::resultT result
);

    typedef enum logic [1:0] {
        stIdle,
        stSeed,
        stGrow,
        stDone
    } stateT;

    stateT state;

    logic pendValid;
    streamPkg::reducedJobT pendJob;
    logic load;

    graphPkg::graphT remainder;
    graphPkg::graphT frontier;
    graphPkg::graphT grown;
    graphPkg::countT count;
    streamPkg::tagT tag;

    // working slot free and a job waiting
    assign load = pendValid && state == stIdle;

    // pending slot
    always_ff @(posedge clk) begin
        if (reset) begin
            pendValid <= 1'b0;
        end else if (inValid) begin
            pendValid <= 1'b1;
        end else if (load) begin
            pendValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            pendJob <= in;
        end
    end

    // one breadth step of the flood fill, kept inside the remainder
    assign grown = (frontier | graphPkg::neighbourhood(frontier)) & remainder;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (load) begin
                        state <= stSeed;
                    end
                end
                stSeed: begin
                    if (remainder == '0) begin
                        state <= stDone;
                    end else begin
                        state <= stGrow;
                    end
                end
                stGrow: begin
                    // component complete once the frontier is stable
                    if (grown == frontier) begin
                        state <= stSeed;
                    end
                end
                stDone: begin
                    if (resultReady) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // working registers
    always_ff @(posedge clk) begin
        case (state)
            stIdle: begin
                if (load) begin
                    remainder <= pendJob.graph;
                    count <= pendJob.singletons;
                    tag <= pendJob.tag;
                end
            end
            stSeed: begin
                frontier <= graphPkg::lowestOnly(remainder);
            end
            stGrow: begin
                if (grown == frontier) begin
                    remainder <= remainder & ~frontier;
                    count <= count + graphPkg::countT'(1);
                end else begin
                    frontier <= grown;
                end
            end
            default: begin
                frontier <= frontier;
            end
        endcase
    end

    // held steady from the registers until taken
    assign resultValid = state == stDone;
    assign result.count = count;
    assign result.tag = tag;

    // a job leaves, so one credit goes back upstream
    assign freeSlot = resultValid && resultReady;

endmodule

// File: source/countingEngine.sv
`timescale 1ns/1ns

module countingEngine (
    input logic clk,
    input logic reset,
    input logic jobValid,
    output logic jobReady,
    input streamPkg::jobT job,
    input graphPkg::graphT bound,
    output logic resultValid,
    input logic resultReady,
    output streamPkg::resultT result
);

    streamPkg::creditT credits;
    logic accept;
    logic freeSlot;

    graphPkg::graphT localBound;
    streamPkg::stagedJobT stagedIn;
    streamPkg::stagedJobT stagedOut;

    logic prepValid;
    streamPkg::reducedJobT prepOut;

    assign jobReady = credits != '0;
    assign accept = jobValid && jobReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= streamPkg::creditT'(streamPkg::jobCredits);
        end else if (accept && !freeSlot) begin
            credits <= credits - streamPkg::creditT'(1);
        end else if (freeSlot && !accept) begin
            credits <= credits + streamPkg::creditT'(1);
        end
    end

    // local copy of the bound, same lag as the job
    delayLine #(
        .payloadT(graphPkg::graphT),
        .depth(streamPkg::boundLag)
    ) boundDelay (
        .clk(clk),
        .reset(reset),
        .in(bound),
        .out(localBound)
    );

    assign stagedIn.valid = accept;
    assign stagedIn.job = job;

    delayLine #(
        .payloadT(streamPkg::stagedJobT),
        .depth(streamPkg::boundLag)
    ) jobDelay (
        .clk(clk),
        .reset(reset),
        .in(stagedIn),
        .out(stagedOut)
    );

    graphPreprocessor preprocessor (
        .clk(clk),
        .reset(reset),
        .inValid(stagedOut.valid),
        .inBound(localBound),
        .inJob(stagedOut.job),
        .outValid(prepValid),
        .out(prepOut)
    );

    componentCounter counter (
        .clk(clk),
        .reset(reset),
        .inValid(prepValid),
        .in(prepOut),
        .freeSlot(freeSlot),
        .resultValid(resultValid),
        .resultReady(resultReady),
        .result(result)
    );

endmodule

// File: source/delayLine.sv
`timescale 1ns/1ns

module delayLine #(
    parameter type payloadT = logic,
    parameter int depth = 1
) (
    input logic clk,
    input logic reset,
    input payloadT in,
    output payloadT out
);

    payloadT stages [depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            // clears any valid bit carried in the payload
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[depth-1];

endmodule

// File: source/graphPkg.sv
package graphPkg;

    // 7-cube, one bit per vertex
    localparam int vertexBits = 7;
    localparam int vertexCount = 1 << vertexBits;

    typedef logic [vertexCount-1:0] graphT;

    // at most 64 isolated vertices, so 7 bits are enough
    typedef logic [vertexBits-1:0] countT;

    // bit v of the result is bit (v ^ 2**dim) of g
    function automatic graphT flipDim(graphT g, int dim);
        graphT r;
        for (int v = 0; v < vertexCount; v++) begin
            r[v] = g[v ^ (1 << dim)];
        end
        return r;
    endfunction

    // vertices with at least one neighbour in g
    function automatic graphT neighbourhood(graphT g);
        graphT r;
        r = '0;
        for (int d = 0; d < vertexBits; d++) begin
            r = r | flipDim(g, d);
        end
        return r;
    endfunction

    // keeps only the lowest set vertex
    function automatic graphT lowestOnly(graphT g);
        return g & (~g + graphT'(1));
    endfunction

endpackage

// File: source/graphPreprocessor.sv
`timescale 1ns/1ns

module graphPreprocessor (
    input logic clk,
    input logic reset,
    input logic inValid,
    input graphPkg::graphT inBound,
    input streamPkg::jobT inJob,
    output logic outValid,
    output streamPkg::reducedJobT out
);

    logic valid1;
    logic valid2;
    logic valid3;
    logic valid4;

    streamPkg::tagT tag1;
    streamPkg::tagT tag2;
    streamPkg::tagT tag3;

    graphPkg::graphT graph1;
    graphPkg::graphT leafFree;
    graphPkg::graphT graph2;
    graphPkg::graphT isolated;
    graphPkg::graphT singletons3;
    graphPkg::graphT remainder3;

    // valid bits only, the payload just follows
    always_ff @(posedge clk) begin
        if (reset) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            valid3 <= 1'b0;
            valid4 <= 1'b0;
        end else begin
            valid1 <= inValid;
            valid2 <= valid1;
            valid3 <= valid2;
            valid4 <= valid3;
        end
    end

    // stage 1: graph = bound minus lower
    always_ff @(posedge clk) begin
        graph1 <= inBound & ~inJob.lower;
        tag1 <= inJob.tag;
    end

    // downward leaf: exactly one neighbour and that one has a lower index.
    // its neighbour can never be a downward leaf itself, so all leaves
    // can go in the same cycle without merging or splitting components
    always_comb begin
        int degree;
        logic hasLower;
        leafFree = graph1;
        for (int v = 0; v < graphPkg::vertexCount; v++) begin
            degree = 0;
            hasLower = 1'b0;
            for (int d = 0; d < graphPkg::vertexBits; d++) begin
                if (graph1[v ^ (1 << d)]) begin
                    degree = degree + 1;
                    if (v[d]) begin
                        hasLower = 1'b1;
                    end
                end
            end
            if (degree == 1 && hasLower) begin
                leafFree[v] = 1'b0;
            end
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        graph2 <= leafFree;
        tag2 <= tag1;
    end

    assign isolated = graph2 & ~graphPkg::neighbourhood(graph2);

    // stage 3: split off isolated vertices
    always_ff @(posedge clk) begin
        singletons3 <= isolated;
        remainder3 <= graph2 & ~isolated;
        tag3 <= tag2;
    end

    // stage 4: singleton popcount
    always_ff @(posedge clk) begin
        out.graph <= remainder3;
        out.singletons <= graphPkg::countT'($countones(singletons3));
        out.tag <= tag3;
    end

    assign outValid = valid4;

endmodule

// File: source/streamPkg.sv
package streamPkg;

    localparam int tagBits = 14;

    // bound tree depth, then the four preprocessor stages
    localparam int boundLag = 2;
    localparam int prepLatency = 4;

    // pipeline plus pending slot
    localparam int jobCredits = 2;
    localparam int creditBits = $clog2(jobCredits + 1);

    typedef logic [tagBits-1:0] tagT;
    typedef logic [creditBits-1:0] creditT;

    typedef struct packed {
        graphPkg::graphT lower;
        tagT tag;
    } jobT;

    // job plus its valid bit, for the alignment delay
    typedef struct packed {
        logic valid;
        jobT job;
    } stagedJobT;

    typedef struct packed {
        graphPkg::graphT graph;
        graphPkg::countT singletons;
        tagT tag;
    } reducedJobT;

    typedef struct packed {
        graphPkg::countT count;
        tagT tag;
    } resultT;

endpackage

// File: testbench/countingEngineTb.sv
`timescale 1ns/1ns

module countingEngineTb;

    typedef logic [127:0] valueT;

    // 300 jobs, 700 cycles each at most
    localparam int jobCycles = 700;
    localparam int cycleLimit = 300 * jobCycles;
    localparam int randomJobsPerBound = 50;
    localparam int heldJobs = 50;

    logic clk;
    logic reset;
    logic jobValid;
    logic jobReady;
    streamPkg::jobT job;
    graphPkg::graphT bound;
    logic resultValid;
    logic resultReady;
    streamPkg::resultT result;

    integer seed;
    integer readySeed;
    logic holdMode;
    streamPkg::tagT tagNext;
    streamPkg::resultT expectQ [$];
    int jobsSent;
    int jobsTaken;
    int outstanding;
    int cycles;
    logic holding;
    streamPkg::resultT heldResult;
    streamPkg::resultT expected;

    countingEngine i_countingEngine (
        .clk(clk),
        .reset(reset),
        .jobValid(jobValid),
        .jobReady(jobReady),
        .job(job),
        .bound(bound),
        .resultValid(resultValid),
        .resultReady(resultReady),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkValue(input string name, input valueT actual, input valueT wanted);
        if (actual !== wanted) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, wanted);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // plain flood fill over bound minus lower, singletons included
    function automatic graphPkg::countT countRef(input graphPkg::graphT jobBound,
                                                 input graphPkg::graphT lower);
        graphPkg::graphT remaining;
        graphPkg::graphT comp;
        logic changed;
        int first;
        int u;
        graphPkg::countT count;
        remaining = jobBound & ~lower;
        count = '0;
        while (remaining != '0) begin
            comp = '0;
            first = 0;
            while (!remaining[first]) begin
                first++;
            end
            comp[first] = 1'b1;
            changed = 1'b1;
            while (changed) begin
                changed = 1'b0;
                for (int v = 0; v < 128; v++) begin
                    for (int d = 0; d < 7; d++) begin
                        u = v ^ (1 << d);
                        if (comp[v] && remaining[u] && !comp[u]) begin
                            comp[u] = 1'b1;
                            changed = 1'b1;
                        end
                    end
                end
            end
            remaining = remaining & ~comp;
            count++;
        end
        return count;
    endfunction

    function automatic graphPkg::graphT randomGraph();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic graphPkg::graphT paritySet(input logic odd);
        graphPkg::graphT g;
        for (int v = 0; v < 128; v++) begin
            g[v] = ($countones(v) % 2 == 1) == odd;
        end
        return g;
    endfunction

    // expected value is queued before the handshake, order is kept
    task automatic sendJob(input graphPkg::graphT lower);
        streamPkg::resultT want;
        job.lower = lower;
        job.tag = tagNext;
        jobValid = 1'b1;
        want.count = countRef(bound, lower);
        want.tag = tagNext;
        expectQ.push_back(want);
        tagNext++;
        jobsSent++;
        while (!jobReady) begin
            @(negedge clk);
        end
        @(negedge clk);
        jobValid = 1'b0;
    endtask

    task automatic sendGraph(input graphPkg::graphT g);
        sendJob(~g);
    endtask

    task automatic drain();
        while (expectQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // bound only moves with nothing in flight
    task automatic setBound(input graphPkg::graphT b);
        drain();
        bound = b;
        repeat (streamPkg::boundLag + 1) @(negedge clk);
    endtask

    // random back-pressure on the result port
    initial begin
        forever begin
            @(negedge clk);
            if (holdMode) begin
                resultReady = ($random(readySeed) & 3) != 0;
            end else begin
                resultReady = 1'b1;
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycleLimit) begin
                $display("timeout after %0d cycles with %0d of %0d results taken", cycles,
                         jobsTaken, jobsSent);
                $display("TEST FAILED");
                $fatal(1, "simulation ran out of cycles");
            end
        end
    end

    // compares on every handshake, pre-edge values
    initial begin
        holding = 1'b0;
        outstanding = 0;
        jobsTaken = 0;
        forever begin
            @(posedge clk);
            if (!reset) begin
                if (holding) begin
                    checkValue("resultValid", valueT'(resultValid), valueT'(1'b1));
                    checkValue("result", valueT'(result), valueT'(heldResult));
                end
                checkValue("jobReady", valueT'(jobReady),
                           valueT'(outstanding < streamPkg::jobCredits));
                if (jobValid && jobReady) begin
                    outstanding++;
                end
                if (resultValid && resultReady) begin
                    if (expectQ.size() == 0) begin
                        $display("a result came out at %0t with no job waiting for it", $time);
                        $display("TEST FAILED");
                        $fatal(1, "unexpected result");
                    end
                    expected = expectQ.pop_front();
                    checkValue("result.count", valueT'(result.count), valueT'(expected.count));
                    checkValue("result.tag", valueT'(result.tag), valueT'(expected.tag));
                    outstanding--;
                    jobsTaken++;
                    holding = 1'b0;
                end else begin
                    holding = resultValid;
                    heldResult = result;
                end
            end
        end
    end

    initial begin
        graphPkg::graphT g;
        seed = 64007;
        readySeed = seed + 1;
        reset = 1'b1;
        jobValid = 1'b0;
        job = '0;
        bound = '1;
        resultReady = 1'b1;
        holdMode = 1'b0;
        tagNext = '0;
        jobsSent = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        checkValue("jobReady", valueT'(jobReady), valueT'(1'b1));
        checkValue("resultValid", valueT'(resultValid), valueT'(1'b0));

        // empty and full graph
        sendJob('1);
        sendJob('0);

        // isolated vertices only
        sendGraph(paritySet(1'b0));
        sendGraph(paritySet(1'b1));

        // monotonic path, every step a downward leaf candidate
        g = '0;
        for (int k = 0; k < 8; k++) begin
            g[(1 << k) - 1] = 1'b1;
        end
        sendGraph(g);

        // star around vertex 0
        g = '0;
        g[0] = 1'b1;
        for (int k = 0; k < 7; k++) begin
            g[1 << k] = 1'b1;
        end
        sendGraph(g);

        // two disjoint chains
        g = '0;
        g[0] = 1'b1;
        g[1] = 1'b1;
        g[3] = 1'b1;
        g[7] = 1'b1;
        g[96] = 1'b1;
        g[97] = 1'b1;
        g[99] = 1'b1;
        g[103] = 1'b1;
        sendGraph(g);

        // sparse graphs, many leaves and singletons
        for (int i = 0; i < 30; i++) begin
            sendGraph(randomGraph() & randomGraph() & randomGraph());
        end

        for (int b = 0; b < 4; b++) begin
            case (b)
                0: setBound('1);
                1: setBound(randomGraph());
                2: setBound(randomGraph() | randomGraph());
                default: setBound(randomGraph() & randomGraph());
            endcase
            for (int i = 0; i < randomJobsPerBound; i++) begin
                if (i % 3 == 0) begin
                    sendJob(randomGraph() | randomGraph());
                end else begin
                    sendJob(randomGraph());
                end
            end
        end

        setBound('1);
        holdMode = 1'b1;
        for (int i = 0; i < heldJobs; i++) begin
            sendJob(randomGraph() | randomGraph());
        end
        drain();
        holdMode = 1'b0;

        // no further results once every job is done
        repeat (jobCycles) @(negedge clk);
        checkValue("resultValid", valueT'(resultValid), valueT'(1'b0));
        $display("TEST PASSED");
        $finish;
    end

endmodule
